// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int addr_len      = 16;
    localparam int line_addr_len = 13;
    localparam int cache_lines   = 8;
    localparam int miss_lines    = 4;
    // 8 is most recently used, 0 is the next victim
    localparam int lru_len       = 4;
    // tag 0 means the request was refused
    localparam int tag_len       = 4;
    localparam int mem_latency   = 4;
    localparam int mem_lines     = 1 << line_addr_len;

    typedef logic [addr_len-1:0]      addr_t;
    typedef logic [line_addr_len-1:0] line_addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [63:0]              block_t;
    typedef logic [lru_len-1:0]       lru_t;
    typedef logic [tag_len-1:0]       mem_tag_t;

    localparam lru_t lru_mru = lru_t'(cache_lines);

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        op_fetch_load  = 2'd0,
        op_fetch_store = 2'd1,
        op_write       = 2'd2
    } miss_op_e;

    ////////////////////////////////////////
    // load/store queue side
    ////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e mem_size;
    } load_req_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } load_resp_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e mem_size;
        word_t     value;
    } store_req_t;

    typedef struct packed {
        logic valid;
    } store_resp_t;

    ////////////////////////////////////////
    // memory side and internal
    ////////////////////////////////////////
    typedef struct packed {
        logic       valid;
        bus_cmd_e   command;
        line_addr_t line_addr;
        block_t     data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t accept_tag;
        logic     valid;
        mem_tag_t tag;
        block_t   data;
    } mem_resp_t;

    // miss queue to line store
    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
        block_t     data;
    } fill_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
        miss_op_e   op;
        block_t     data;
    } miss_alloc_t;

endpackage

`default_nettype wire

// ==== cache_line_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_line_store (
    input  logic                   clock,
    input  logic                   reset,
    input  dcache_pkg::load_req_t  load_req,
    input  dcache_pkg::store_req_t store_req,
    input  dcache_pkg::fill_t      fill,
    output logic                   load_hit,
    output dcache_pkg::word_t      load_value,
    output logic                   store_hit,
    output dcache_pkg::block_t     store_line,
    input  logic                   store_commit
);

    logic [dcache_pkg::cache_lines-1:0]                         line_valid, f_valid, n_valid;
    dcache_pkg::line_addr_t [dcache_pkg::cache_lines-1:0]       line_tag, f_tag, n_tag;
    dcache_pkg::block_t [dcache_pkg::cache_lines-1:0]           line_data, f_data, n_data;
    dcache_pkg::lru_t [dcache_pkg::cache_lines-1:0]             line_lru, f_lru, n_lru;

    logic [$clog2(dcache_pkg::cache_lines)-1:0] load_idx, store_idx, touch_idx;
    logic                                       fill_present, fill_placed, touch;
    dcache_pkg::lru_t                           old_lru;
    dcache_pkg::block_t                         load_line;

    // fill first, so a line arriving this cycle already hits
    always_comb begin
        f_valid      = line_valid;
        f_tag        = line_tag;
        f_data       = line_data;
        f_lru        = line_lru;
        fill_present = 1'b0;
        fill_placed  = 1'b0;
        if (fill.valid) begin
            for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
                if (line_valid[i] && line_tag[i] == fill.line_addr) begin
                    fill_present = 1'b1;
                    f_data[i]    = fill.data;
                end
            end
            if (!fill_present) begin
                // age every used line, the oldest then sits at 0
                for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
                    if (f_lru[i] != '0) f_lru[i] = f_lru[i] - 1'b1;
                end
                for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
                    if (!fill_placed && f_lru[i] == '0) begin
                        fill_placed = 1'b1;
                        f_valid[i]  = 1'b1;
                        f_tag[i]    = fill.line_addr;
                        f_data[i]   = fill.data;
                        f_lru[i]    = dcache_pkg::lru_mru;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////
    always_comb begin
        load_hit  = 1'b0;
        store_hit = 1'b0;
        load_idx  = '0;
        store_idx = '0;
        for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
            if (load_req.valid && f_valid[i] &&
                f_tag[i] == load_req.addr[dcache_pkg::addr_len-1:3]) begin
                load_hit = 1'b1;
                load_idx = $bits(load_idx)'(i);
            end
            if (store_req.valid && f_valid[i] &&
                f_tag[i] == store_req.addr[dcache_pkg::addr_len-1:3]) begin
                store_hit = 1'b1;
                store_idx = $bits(store_idx)'(i);
            end
        end

        load_line = f_data[load_idx];
        case (load_req.mem_size)
            dcache_pkg::mem_byte: load_value = {24'b0, load_line[{load_req.addr[2:0], 3'b000} +: 8]};
            dcache_pkg::mem_half: load_value = {16'b0, load_line[{load_req.addr[2:1], 4'b0000} +: 16]};
            default:              load_value = load_line[{load_req.addr[2], 5'b00000} +: 32];
        endcase

        // merged line for the store, also what goes to memory
        store_line = f_data[store_idx];
        case (store_req.mem_size)
            dcache_pkg::mem_byte: store_line[{store_req.addr[2:0], 3'b000} +: 8]  = store_req.value[7:0];
            dcache_pkg::mem_half: store_line[{store_req.addr[2:1], 4'b0000} +: 16] = store_req.value[15:0];
            default:              store_line[{store_req.addr[2], 5'b00000} +: 32]  = store_req.value;
        endcase
    end

    // load touches first, then a committed store
    always_comb begin
        n_valid   = f_valid;
        n_tag     = f_tag;
        n_data    = f_data;
        n_lru     = f_lru;
        touch     = 1'b0;
        touch_idx = '0;
        old_lru   = '0;
        if (store_commit) n_data[store_idx] = store_line;
        for (int u = 0; u < 2; u++) begin
            touch     = (u == 0) ? load_hit : store_commit;
            touch_idx = (u == 0) ? load_idx : store_idx;
            if (touch) begin
                old_lru = n_lru[touch_idx];
                for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
                    if (n_lru[i] > old_lru) n_lru[i] = n_lru[i] - 1'b1;
                end
                n_lru[touch_idx] = dcache_pkg::lru_mru;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_lru   <= '0;
        end else begin
            line_valid <= n_valid;
            line_lru   <= n_lru;
        end
    end

    always_ff @(posedge clock) begin
        line_tag  <= n_tag;
        line_data <= n_data;
    end

endmodule

`default_nettype wire

// ==== miss_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module miss_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::miss_alloc_t alloc,
    input  dcache_pkg::line_addr_t  lookup_line,
    output logic                    line_pending,
    output logic                    has_free,
    output logic                    writes_drained,
    output dcache_pkg::mem_req_t    mem_req,
    input  dcache_pkg::mem_resp_t   mem_resp,
    output dcache_pkg::fill_t       fill
);

    localparam int ml = dcache_pkg::miss_lines;

    logic [ml-1:0]                  ent_valid, ent_sent;
    dcache_pkg::mem_tag_t [ml-1:0]  ent_tag;
    dcache_pkg::line_addr_t [ml-1:0] ent_line;
    dcache_pkg::miss_op_e [ml-1:0]  ent_op;
    dcache_pkg::block_t [ml-1:0]    ent_data;
    // older[i][j] set when entry i was allocated before entry j
    logic [ml-1:0][ml-1:0]          older;

    logic [$clog2(ml)-1:0] issue_idx, resp_idx, alloc_idx;
    logic                  issue_found, resp_found, blocked, accepted;

    ////////////////////////////////////////
    // status towards dcache
    ////////////////////////////////////////
    always_comb begin
        line_pending   = 1'b0;
        has_free       = 1'b0;
        writes_drained = 1'b1;
        alloc_idx      = '0;
        for (int i = ml - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent_line[i] == lookup_line) line_pending = 1'b1;
            if (ent_valid[i] && ent_op[i] == dcache_pkg::op_write) writes_drained = 1'b0;
            if (!ent_valid[i]) begin
                has_free  = 1'b1;
                alloc_idx = $bits(alloc_idx)'(i);
            end
        end
    end

    // oldest entry not yet sent
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        blocked     = 1'b0;
        for (int i = 0; i < ml; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < ml; j++) begin
                if (ent_valid[j] && !ent_sent[j] && older[j][i]) blocked = 1'b1;
            end
            if (ent_valid[i] && !ent_sent[i] && !blocked) begin
                issue_found = 1'b1;
                issue_idx   = $bits(issue_idx)'(i);
            end
        end
        mem_req.valid     = issue_found;
        mem_req.command   = (ent_op[issue_idx] == dcache_pkg::op_write) ?
                            dcache_pkg::bus_store : dcache_pkg::bus_load;
        mem_req.line_addr = ent_line[issue_idx];
        mem_req.data      = ent_data[issue_idx];
        accepted          = issue_found && mem_resp.accept_tag != '0;
    end

    // response matching, fetches turn into fills
    always_comb begin
        resp_found = 1'b0;
        resp_idx   = '0;
        for (int i = 0; i < ml; i++) begin
            if (mem_resp.valid && ent_valid[i] && ent_sent[i] && ent_tag[i] == mem_resp.tag) begin
                resp_found = 1'b1;
                resp_idx   = $bits(resp_idx)'(i);
            end
        end
        fill.valid     = resp_found && ent_op[resp_idx] != dcache_pkg::op_write;
        fill.line_addr = ent_line[resp_idx];
        fill.data      = mem_resp.data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            ent_sent  <= '0;
            older     <= '0;
        end else begin
            if (accepted) ent_sent[issue_idx] <= 1'b1;
            if (resp_found) ent_valid[resp_idx] <= 1'b0;
            if (alloc.valid && has_free) begin
                ent_valid[alloc_idx] <= 1'b1;
                ent_sent[alloc_idx]  <= 1'b0;
                for (int j = 0; j < ml; j++) begin
                    older[j][alloc_idx] <= ent_valid[j];
                    older[alloc_idx][j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) ent_tag[issue_idx] <= mem_resp.accept_tag;
        if (alloc.valid && has_free) begin
            ent_line[alloc_idx] <= alloc.line_addr;
            ent_op[alloc_idx]   <= alloc.op;
            ent_data[alloc_idx] <= alloc.data;
        end
    end

endmodule

`default_nettype wire

// ==== dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::load_req_t   load_req,
    input  dcache_pkg::store_req_t  store_req,
    output dcache_pkg::load_resp_t  load_resp,
    output dcache_pkg::store_resp_t store_resp,
    output logic                    writes_drained,
    output dcache_pkg::mem_req_t    mem_req,
    input  dcache_pkg::mem_resp_t   mem_resp
);

    logic                    load_hit, store_hit, store_commit;
    logic                    line_pending, has_free;
    dcache_pkg::word_t       load_value;
    dcache_pkg::block_t      store_line;
    dcache_pkg::fill_t       fill;
    dcache_pkg::miss_alloc_t alloc;
    dcache_pkg::line_addr_t  load_line_addr, store_line_addr, lookup_line;

    assign load_line_addr  = load_req.addr[dcache_pkg::addr_len-1:3];
    assign store_line_addr = store_req.addr[dcache_pkg::addr_len-1:3];

    // a store in the cycle owns the pending lookup
    assign lookup_line = store_req.valid ? store_line_addr : load_line_addr;

    cache_line_store u_lines (
        .clock        (clock),
        .reset        (reset),
        .load_req     (load_req),
        .store_req    (store_req),
        .fill         (fill),
        .load_hit     (load_hit),
        .load_value   (load_value),
        .store_hit    (store_hit),
        .store_line   (store_line),
        .store_commit (store_commit)
    );

    miss_queue u_miss (
        .clock          (clock),
        .reset          (reset),
        .alloc          (alloc),
        .lookup_line    (lookup_line),
        .line_pending   (line_pending),
        .has_free       (has_free),
        .writes_drained (writes_drained),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .fill           (fill)
    );

    ////////////////////////////////////////
    // allocation, store need wins
    ////////////////////////////////////////
    always_comb begin
        alloc.valid     = 1'b0;
        alloc.line_addr = load_line_addr;
        alloc.op        = dcache_pkg::op_fetch_load;
        alloc.data      = '0;
        if (store_req.valid && store_hit) begin
            alloc.valid     = has_free;
            alloc.line_addr = store_line_addr;
            alloc.op        = dcache_pkg::op_write;
            alloc.data      = store_line;
        end else if (store_req.valid) begin
            // store miss, fetch and let the queue replay
            alloc.valid     = !line_pending && has_free;
            alloc.line_addr = store_line_addr;
            alloc.op        = dcache_pkg::op_fetch_store;
        end else if (load_req.valid && !load_hit) begin
            alloc.valid = !line_pending && has_free;
        end
    end

    assign store_commit = store_req.valid && store_hit && has_free;

    assign load_resp.valid  = load_hit;
    assign load_resp.value  = load_value;
    assign store_resp.valid = store_commit;

endmodule

`default_nettype wire

// ==== dmem.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);

    localparam int lat = dcache_pkg::mem_latency;

    dcache_pkg::block_t mem [dcache_pkg::mem_lines] = '{default: '0};

    // tag 0 is never handed out
    logic [(1 << dcache_pkg::tag_len)-1:1] tag_busy;
    dcache_pkg::mem_tag_t                  free_tag;
    logic                                  accept;

    // delay pipeline, last stage is the response
    logic [lat-1:0]                   pipe_valid;
    dcache_pkg::bus_cmd_e [lat-1:0]   pipe_cmd;
    dcache_pkg::mem_tag_t [lat-1:0]   pipe_tag;
    dcache_pkg::line_addr_t [lat-1:0] pipe_line;

    always_comb begin
        free_tag = '0;
        for (int t = (1 << dcache_pkg::tag_len) - 1; t >= 1; t--) begin
            if (!tag_busy[t]) free_tag = dcache_pkg::mem_tag_t'(t);
        end
        accept = mem_req.valid && free_tag != '0;
    end

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////
    assign mem_resp.accept_tag = accept ? free_tag : '0;
    assign mem_resp.valid      = pipe_valid[lat-1];
    assign mem_resp.tag        = pipe_tag[lat-1];
    // loads read when due, so earlier stores are seen
    assign mem_resp.data       = (pipe_cmd[lat-1] == dcache_pkg::bus_load) ?
                                 mem[pipe_line[lat-1]] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            pipe_valid <= '0;
            tag_busy   <= '0;
        end else begin
            pipe_valid <= {pipe_valid[lat-2:0], accept};
            if (pipe_valid[lat-1]) tag_busy[pipe_tag[lat-1]] <= 1'b0;
            if (accept) tag_busy[free_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        for (int k = lat - 1; k > 0; k--) begin
            pipe_cmd[k]  <= pipe_cmd[k-1];
            pipe_tag[k]  <= pipe_tag[k-1];
            pipe_line[k] <= pipe_line[k-1];
        end
        pipe_cmd[0]  <= mem_req.command;
        pipe_tag[0]  <= free_tag;
        pipe_line[0] <= mem_req.line_addr;
        // stores land at acceptance
        if (accept && mem_req.command == dcache_pkg::bus_store) begin
            mem[mem_req.line_addr] <= mem_req.data;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::load_req_t   load_req,
    input  dcache_pkg::store_req_t  store_req,
    output dcache_pkg::load_resp_t  load_resp,
    output dcache_pkg::store_resp_t store_resp,
    output logic                    writes_drained
);

    // dedicated memory port
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    dcache u_dcache (
        .clock          (clock),
        .reset          (reset),
        .load_req       (load_req),
        .store_req      (store_req),
        .load_resp      (load_resp),
        .store_resp     (store_resp),
        .writes_drained (writes_drained),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp)
    );

    dmem u_dmem (
        .clock    (clock),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule

`default_nettype wire

// ==== tb_dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_top;

    localparam int timeout_cycles = 200;

    logic                    clock;
    logic                    reset;
    dcache_pkg::load_req_t   load_req;
    dcache_pkg::store_req_t  store_req;
    dcache_pkg::load_resp_t  load_resp;
    dcache_pkg::store_resp_t store_resp;
    logic                    writes_drained;

    // byte model of memory with little endian lines
    logic [7:0] model_mem [0:65535] = '{default: 8'h00};
    int         value_errors = 0;
    int         timeout_errors = 0;
    int         seed_value;

    dcache_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .load_req       (load_req),
        .store_req      (store_req),
        .load_resp      (load_resp),
        .store_resp     (store_resp),
        .writes_drained (writes_drained)
    );

    always #50 clock = ~clock;

    ////////////////////////////////////////
    // compare tasks and model
    ////////////////////////////////////////
    task automatic check_word(input string what, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic int size_bytes(input dcache_pkg::mem_size_e size);
        case (size)
            dcache_pkg::mem_byte: return 1;
            dcache_pkg::mem_half: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic dcache_pkg::word_t expected_value(input dcache_pkg::addr_t addr,
                                                        input dcache_pkg::mem_size_e size);
        dcache_pkg::word_t v;
        v = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            v[8*k +: 8] = model_mem[addr + dcache_pkg::addr_t'(k)];
        end
        return v;
    endfunction

    task automatic record_store(input dcache_pkg::addr_t addr, input dcache_pkg::mem_size_e size,
                                input dcache_pkg::word_t value);
        for (int k = 0; k < size_bytes(size); k++) begin
            model_mem[addr + dcache_pkg::addr_t'(k)] = value[8*k +: 8];
        end
    endtask

    ////////////////////////////////////////
    // request helpers that replay until answered
    ////////////////////////////////////////
    task automatic do_load(input dcache_pkg::addr_t addr, input dcache_pkg::mem_size_e size,
                           output dcache_pkg::word_t value, output int replays);
        logic done;
        done    = 1'b0;
        replays = 0;
        value   = '0;
        while (!done && replays < timeout_cycles) begin
            @(negedge clock);
            store_req.valid   = 1'b0;
            load_req.valid    = 1'b1;
            load_req.addr     = addr;
            load_req.mem_size = size;
            #10;
            if (load_resp.valid) begin
                done  = 1'b1;
                value = load_resp.value;
            end else begin
                replays++;
            end
        end
        if (!done) begin
            timeout_errors++;
            $display("timeout: load of address %h never answered", addr);
        end
    endtask

    task automatic do_store(input dcache_pkg::addr_t addr, input dcache_pkg::mem_size_e size,
                            input dcache_pkg::word_t value, output int replays);
        logic done;
        done    = 1'b0;
        replays = 0;
        while (!done && replays < timeout_cycles) begin
            @(negedge clock);
            load_req.valid     = 1'b0;
            store_req.valid    = 1'b1;
            store_req.addr     = addr;
            store_req.mem_size = size;
            store_req.value    = value;
            #10;
            if (store_resp.valid) begin
                done = 1'b1;
                record_store(addr, size, value);
            end else begin
                replays++;
            end
        end
        if (!done) begin
            timeout_errors++;
            $display("timeout: store to address %h never acknowledged", addr);
        end
    endtask

    // idle until all writes are out and note whether any was pending
    task automatic wait_drained(output logic saw_low);
        logic done;
        int   cycles;
        done    = 1'b0;
        cycles  = 0;
        saw_low = 1'b0;
        while (!done && cycles < timeout_cycles) begin
            @(negedge clock);
            load_req.valid  = 1'b0;
            store_req.valid = 1'b0;
            #10;
            if (writes_drained) done = 1'b1;
            else saw_low = 1'b1;
            cycles++;
        end
        if (!done) begin
            timeout_errors++;
            $display("timeout: writes_drained stayed low");
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic idle_after_reset();
        dcache_pkg::word_t v;
        int                r;
        check_flag("writes_drained after reset", writes_drained, 1'b1);
        do_load(16'h1230, dcache_pkg::mem_word, v, r);
        check_word("load of unwritten address", v, 32'h0);
        check_flag("first load replayed", r != 0, 1'b1);
    endtask

    task automatic store_miss_sizes();
        dcache_pkg::word_t v;
        int                r;
        do_store(16'h0400, dcache_pkg::mem_word, $urandom, r);
        check_flag("store miss replayed", r != 0, 1'b1);
        do_load(16'h0401, dcache_pkg::mem_byte, v, r);
        check_word("byte load", v, expected_value(16'h0401, dcache_pkg::mem_byte));
        do_load(16'h0402, dcache_pkg::mem_half, v, r);
        check_word("half load", v, expected_value(16'h0402, dcache_pkg::mem_half));
        do_load(16'h0400, dcache_pkg::mem_word, v, r);
        check_word("word load", v, expected_value(16'h0400, dcache_pkg::mem_word));
    endtask

    task automatic hit_without_replay();
        dcache_pkg::word_t v;
        int                r;
        do_store(16'h0404, dcache_pkg::mem_word, $urandom, r);
        check_flag("store hit without replay", r == 0, 1'b1);
        do_load(16'h0404, dcache_pkg::mem_word, v, r);
        check_flag("load after store hit without replay", r == 0, 1'b1);
        check_word("load after store hit", v, expected_value(16'h0404, dcache_pkg::mem_word));
    endtask

    task automatic write_through_eviction();
        dcache_pkg::word_t v;
        dcache_pkg::addr_t a;
        int                r;
        logic              saw_low;
        for (int i = 0; i < 6; i++) begin
            a = ((i % 2) == 0) ? 16'h0400 : 16'h1230;
            a = a + dcache_pkg::addr_t'(4 * ((i / 2) % 2));
            do_store(a, dcache_pkg::mem_word, $urandom, r);
        end
        wait_drained(saw_low);
        check_flag("writes pending after burst", saw_low, 1'b1);
        // ten new lines push the stored ones out
        for (int i = 0; i < 10; i++) begin
            a = 16'h2000 + dcache_pkg::addr_t'(8 * i);
            do_load(a, dcache_pkg::mem_word, v, r);
            check_word("load of fresh line", v, 32'h0);
        end
        do_load(16'h0400, dcache_pkg::mem_word, v, r);
        check_flag("stored line was evicted", r != 0, 1'b1);
        check_word("reload 0x0400", v, expected_value(16'h0400, dcache_pkg::mem_word));
        do_load(16'h0404, dcache_pkg::mem_word, v, r);
        check_word("reload 0x0404", v, expected_value(16'h0404, dcache_pkg::mem_word));
        do_load(16'h1230, dcache_pkg::mem_word, v, r);
        check_word("reload 0x1230", v, expected_value(16'h1230, dcache_pkg::mem_word));
        do_load(16'h1234, dcache_pkg::mem_word, v, r);
        check_word("reload 0x1234", v, expected_value(16'h1234, dcache_pkg::mem_word));
    endtask

    task automatic lru_victim();
        dcache_pkg::word_t v;
        int                r;
        for (int i = 0; i < 8; i++) begin
            do_load(16'h3000 + dcache_pkg::addr_t'(8 * i), dcache_pkg::mem_word, v, r);
        end
        do_load(16'h3000, dcache_pkg::mem_word, v, r);
        check_flag("A0 hit before A8 fill", r == 0, 1'b1);
        do_load(16'h3040, dcache_pkg::mem_word, v, r);
        do_load(16'h3000, dcache_pkg::mem_word, v, r);
        check_flag("A0 kept after A8 fill", r == 0, 1'b1);
        do_load(16'h3008, dcache_pkg::mem_word, v, r);
        check_flag("A1 evicted by A8 fill", r != 0, 1'b1);
    endtask

    task automatic random_mix();
        dcache_pkg::word_t     v;
        dcache_pkg::addr_t     a;
        dcache_pkg::mem_size_e size;
        int                    r;
        int                    off;
        logic                  saw_low;
        for (int n = 0; n < 60; n++) begin
            case ($urandom % 3)
                0:       size = dcache_pkg::mem_byte;
                1:       size = dcache_pkg::mem_half;
                default: size = dcache_pkg::mem_word;
            endcase
            // aligned to the access size
            off = ($urandom % 8) & ~(size_bytes(size) - 1);
            a   = 16'h5000 + dcache_pkg::addr_t'(8 * ($urandom % 12) + off);
            if ($urandom % 2 == 0) begin
                do_store(a, size, $urandom, r);
            end else begin
                do_load(a, size, v, r);
                check_word($sformatf("random load at %h", a), v, expected_value(a, size));
            end
        end
        wait_drained(saw_low);
    endtask

    initial begin
        seed_value = $urandom(79608);
        clock      = 1'b0;
        reset      = 1'b1;
        load_req   = '0;
        store_req  = '0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        #10;

        idle_after_reset();
        store_miss_sizes();
        hit_without_replay();
        write_through_eviction();
        lru_victim();
        random_mix();

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
dcache_pkg.sv
cache_line_store.sv
miss_queue.sv
dcache.sv
dmem.sv
dcache_top.sv
tb_dcache_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing -Wno-fatal --top-module tb_dcache_top -f all.f \
    -o sim_dcache > build.log 2>&1 \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished"; exit 0; }
